// ==== sim/lifeGolden.txt ====
# columns: start board, expected board after one generation (both hex), expected stallFlag
# bit index = row*4 + column, so the rightmost hex digit is row 0
# empty board, nothing active
0000 0000 1
# single live cell at row 0 column 0
0001 0000 1
# single live cell at row 3 column 3
8000 0000 1
# all ones, every count is 8
ffff 0000 0
# two neighbours, count 2 at most
0003 0000 0
# horizontal line on row 1
0070 0202 0
# four corners form a block across both wraps
9009 9009 0
# plus sign, counts 3 and 4
0272 0777 0
# rows 0 and 1 full, counts 5 and 3
00ff ffff 0
# rows 0 to 2 full, counts 5, 8 and 6
0fff 0f0f 0
# diagonal, every count is 2
8421 0000 0
# L shape in the corner
0013 0020 0

// ==== list.f ====
+incdir+verilog
verilog/lifeBoardPkg.sv
verilog/lifeRulePkg.sv
verilog/neighborCounter.sv
verilog/cellRule.sv
verilog/boardBuffer.sv
verilog/lifeTop.sv
sim/clockGen.sv
sim/lifeTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the life testbench with Verilator, from the project root
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module lifeTb -o lifeSim \
  > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/lifeSim > sim.log 2>&1
grep -q "test failed" sim.log && { echo "FAIL, see sim.log"; exit 1; }
grep -q "test passed" sim.log || { echo "FAIL, no pass message in sim.log"; exit 1; }
echo "PASS"
exit 0

// ==== sim/lifeTb.sv ====
//----------------------------------------------------------
// testbench for lifeTop, records come from sim/lifeGolden.txt
// run from the project root so the golden path resolves
// stops at the first mismatch, strobes go 1 ns after edges
//----------------------------------------------------------
`timescale 1ns/10ps
`include "lifeGrid_params.svh"

module lifeTb
  import lifeBoardPkg::*, lifeRulePkg::*;
();

  localparam string GOLDEN_PATH       = "sim/lifeGolden.txt";
  localparam int    RESET_CYCLES      = 10;
  // one record takes about 53 cycles
  localparam int    CYCLES_PER_RECORD = 60;

  // DUT ports
  logic      clka;
  logic      arstN;
  logic      clearBoard;
  logic      loadCell;
  logic      readCell;
  logic      writeCell;
  logic      commitGen;
  cellIndexT cellIndex;
  logic      cellData;
  boardT     board;
  logic      stallFlag;

  // golden records: start, expected next board, expected quiet flag
  boardT startQ[$];
  boardT nextQ[$];
  logic  stallQ[$];

  int errorCount;
  int cycleCount;
  // generous until the golden file has been counted
  int cycleLimit = 1000000;

  clockGen #(
    .HALF_PERIOD  (10),
    .RESET_CYCLES (RESET_CYCLES)
  ) clockGen_inst (
    .clka  (clka),
    .arstN (arstN)
  );

  lifeTop lifeTop_inst (
    .clka       (clka),
    .arstN      (arstN),
    .clearBoard (clearBoard),
    .loadCell   (loadCell),
    .readCell   (readCell),
    .writeCell  (writeCell),
    .commitGen  (commitGen),
    .cellIndex  (cellIndex),
    .cellData   (cellData),
    .board      (board),
    .stallFlag  (stallFlag)
  );

  //----------------------------------------------------------
  // failure and compare helpers
  //----------------------------------------------------------
  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("test failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic checkBoard(input string where, input boardT expected, input boardT actual);
    if (actual !== expected) begin
      errorCount++;
      $display("ERR board expected 0x%h actual 0x%h (%s)", expected, actual, where);
      abortRun("board mismatch");
    end
  endtask

  task automatic checkFlag(input string where, input logic expected, input logic actual);
    if (actual !== expected) begin
      errorCount++;
      $display("ERR stallFlag expected 0x%h actual 0x%h (%s)", expected, actual, where);
      abortRun("stallFlag mismatch");
    end
  endtask

  //----------------------------------------------------------
  // golden file
  //----------------------------------------------------------
  // full-line comments start with #, blank lines skipped
  task automatic readGolden();
    int         fd;
    int         got;
    int         lineNo;
    string      line;
    boardT      startPat;
    boardT      nextPat;
    logic [3:0] flagVal;
    lineNo = 0;
    fd = $fopen(GOLDEN_PATH, "r");
    if (fd == 0) begin
      abortRun($sformatf("cannot open the golden file %s", GOLDEN_PATH));
    end
    while (!$feof(fd)) begin
      line = "";
      got = $fgets(line, fd);
      lineNo++;
      if (got > 0 && line.len() > 1 && line[0] != "#") begin
        got = $sscanf(line, "%h %h %h", startPat, nextPat, flagVal);
        if (got != 3 || flagVal > 4'd1) begin
          abortRun($sformatf("golden file line %0d is not a valid record", lineNo));
        end
        startQ.push_back(startPat);
        nextQ.push_back(nextPat);
        stallQ.push_back(flagVal[0]);
      end
    end
    $fclose(fd);
    if (startQ.size() == 0) begin
      abortRun("the golden file holds no records");
    end
  endtask

  //----------------------------------------------------------
  // strobe drivers
  //----------------------------------------------------------
  // lands 1 ns after the next rising edge
  task automatic nextEdge();
    @(posedge clka);
    #1;
  endtask

  task automatic pulseClear();
    clearBoard = 1'b1;
    nextEdge();
    clearBoard = 1'b0;
  endtask

  task automatic pulseCommit();
    commitGen = 1'b1;
    nextEdge();
    commitGen = 1'b0;
  endtask

  // serial load of every cell into the next buffer
  task automatic loadPattern(input boardT pattern);
    for (int i = 0; i < `CELL_COUNT; i++) begin
      loadCell  = 1'b1;
      cellIndex = cellIndexT'(i);
      cellData  = pattern[i];
      nextEdge();
      loadCell  = 1'b0;
    end
  endtask

  // read then write back, index held across both edges
  task automatic evaluateCells(input int cellsToDo);
    for (int i = 0; i < cellsToDo; i++) begin
      cellIndex = cellIndexT'(i);
      readCell  = 1'b1;
      nextEdge();
      readCell  = 1'b0;
      writeCell = 1'b1;
      nextEdge();
      writeCell = 1'b0;
    end
  endtask

  //----------------------------------------------------------
  // test sequences
  //----------------------------------------------------------
  // one generation, alive when BIRTH_MIN <= count <= BIRTH_MAX
  task automatic runRecord(input int rec);
    string tag;
    tag = $sformatf("record %0d", rec);
    pulseClear();
    checkBoard({tag, " after clear"}, '0, board);
    checkFlag({tag, " after clear"}, 1'b0, stallFlag);
    loadPattern(startQ[rec]);
    // loads stay in the buffer until commit
    checkBoard({tag, " loaded, not committed"}, '0, board);
    pulseCommit();
    checkBoard({tag, " after load commit"}, startQ[rec], board);
    // nothing written yet, so the generation counts as quiet
    checkFlag({tag, " after load commit"}, 1'b1, stallFlag);
    evaluateCells(`CELL_COUNT);
    checkBoard({tag, " before generation commit"}, startQ[rec], board);
    pulseCommit();
    checkBoard({tag, " after generation"}, nextQ[rec], board);
    checkFlag({tag, " after generation"}, stallQ[rec], stallFlag);
  endtask

  // clear in the middle of a pass drops board, buffer and activity
  task automatic clearMidSequence(input boardT pattern);
    pulseClear();
    loadPattern(pattern);
    pulseCommit();
    checkBoard("mid-clear setup", pattern, board);
    checkFlag("mid-clear setup", 1'b1, stallFlag);
    // a second load must not reach the board
    loadPattern(~pattern);
    checkBoard("second load, not committed", pattern, board);
    evaluateCells(4);
    pulseClear();
    checkBoard("after mid-sequence clear", '0, board);
    checkFlag("after mid-sequence clear", 1'b0, stallFlag);
    // empty buffer, no activity left
    pulseCommit();
    checkBoard("commit after clear", '0, board);
    checkFlag("commit after clear", 1'b1, stallFlag);
  endtask

  //----------------------------------------------------------
  // main sequence
  //----------------------------------------------------------
  initial begin : mainSeq
    clearBoard = 1'b0;
    loadCell   = 1'b0;
    readCell   = 1'b0;
    writeCell  = 1'b0;
    commitGen  = 1'b0;
    cellIndex  = '0;
    cellData   = 1'b0;
    errorCount = 0;
    readGolden();
    cycleLimit = RESET_CYCLES + 20 + (startQ.size() + 1) * CYCLES_PER_RECORD;
    @(posedge arstN);
    checkBoard("after reset", '0, board);
    checkFlag("after reset", 1'b0, stallFlag);
    for (int rec = 0; rec < startQ.size(); rec++) begin
      runRecord(rec);
    end
    clearMidSequence(startQ[startQ.size() - 1]);
    if (errorCount == 0) begin
      $display("test passed");
      $finish;
    end else begin
      $display("test failed");
      $fatal(1, "checks failed");
    end
  end

  // cycle budget, scaled by the record count
  initial begin : watchdog
    cycleCount = 0;
    while (cycleCount <= cycleLimit) begin
      @(posedge clka);
      cycleCount++;
    end
    abortRun($sformatf("timeout, no result within %0d clock cycles", cycleLimit));
  end

endmodule

// ==== sim/clockGen.sv ====
//----------------------------------------------------------
// testbench clock and reset source
// reset held low for RESET_CYCLES rising edges
// release lands 1 ns after an edge, like all stimulus
//----------------------------------------------------------
`timescale 1ns/10ps

module clockGen #(
  parameter int HALF_PERIOD  = 10,
  parameter int RESET_CYCLES = 10
) (
  output logic clka,
  output logic arstN
);

  // free-running clock, 20 ns period by default
  initial begin
    clka = 1'b0;
    forever #(HALF_PERIOD) clka = ~clka;
  end

  // power-on reset
  initial begin
    arstN = 1'b0;
    repeat (RESET_CYCLES) @(posedge clka);
    #1 arstN = 1'b1;
  end

endmodule

// ==== verilog/lifeTop.sv ====
//----------------------------------------------------------
// life datapath top, counter + rule + buffer
// all sequencing comes from the one-cycle strobes
// at most one strobe high per edge, no back-pressure
//----------------------------------------------------------
`timescale 1ns/10ps

module lifeTop
  import lifeBoardPkg::*, lifeRulePkg::*;
(
  input  logic      clka,
  input  logic      arstN,
  input  logic      clearBoard,
  input  logic      loadCell,
  input  logic      readCell,
  input  logic      writeCell,
  input  logic      commitGen,
  input  cellIndexT cellIndex,
  input  logic      cellData,
  output boardT     board,
  output logic      stallFlag
);

  //----------------------------------------------------------
  // internal wires
  //----------------------------------------------------------
  // counter to rule
  neighborCountT neighborCount;
  // latched decision to buffer
  logic          nextCell;

  // live neighbours of the indexed cell on the visible board
  neighborCounter neighborCounter_inst (
    .board         (board),
    .cellIndex     (cellIndex),
    .neighborCount (neighborCount)
  );

  // decision latch, activity and quiet flag
  cellRule cellRule_inst (
    .clka          (clka),
    .arstN         (arstN),
    .clearBoard    (clearBoard),
    .readCell      (readCell),
    .writeCell     (writeCell),
    .commitGen     (commitGen),
    .neighborCount (neighborCount),
    .nextCell      (nextCell),
    .stallFlag     (stallFlag)
  );

  // buffer and visible board, board loops back to the counter
  boardBuffer boardBuffer_inst (
    .clka       (clka),
    .arstN      (arstN),
    .clearBoard (clearBoard),
    .loadCell   (loadCell),
    .writeCell  (writeCell),
    .commitGen  (commitGen),
    .cellIndex  (cellIndex),
    .cellData   (cellData),
    .nextCell   (nextCell),
    .board      (board)
  );

endmodule

// ==== verilog/boardBuffer.sv ====
//----------------------------------------------------------
// next-generation buffer and visible board register
// loads and write-backs go to the buffer, one bit per edge
// board only moves on commitGen or clearBoard
//----------------------------------------------------------
`timescale 1ns/10ps

module boardBuffer
  import lifeBoardPkg::*;
(
  input  logic      clka,
  input  logic      arstN,
  input  logic      clearBoard,
  input  logic      loadCell,
  input  logic      writeCell,
  input  logic      commitGen,
  input  cellIndexT cellIndex,
  input  logic      cellData,
  input  logic      nextCell,
  output boardT     board
);

  // generation being built, invisible until commit
  boardT nextBuf;

  //----------------------------------------------------------
  // next-generation buffer
  //----------------------------------------------------------
  always_ff @(posedge clka or negedge arstN) begin
    if (!arstN) begin
      nextBuf <= '0;
    end else if (clearBoard) begin
      nextBuf <= '0;
    end else if (loadCell) begin
      // pattern load from outside
      nextBuf[cellIndex] <= cellData;
    end else if (writeCell) begin
      // rule result for the same index
      nextBuf[cellIndex] <= nextCell;
    end
  end

  //----------------------------------------------------------
  // visible board
  //----------------------------------------------------------
  // also feeds the neighbour counter
  always_ff @(posedge clka or negedge arstN) begin
    if (!arstN) begin
      board <= '0;
    end else if (clearBoard) begin
      board <= '0;
    end else if (commitGen) begin
      // whole generation at once
      board <= nextBuf;
    end
  end

  //----------------------------------------------------------
  // checks
  //----------------------------------------------------------
  // only one writer into the buffer per edge
  aSingleWriter: assert property (@(posedge clka) disable iff (!arstN)
    !(loadCell && writeCell))
    else $error("boardBuffer: loadCell and writeCell together");

  // the counter relies on a stable board during a generation pass
  aBoardStable: assert property (@(posedge clka) disable iff (!arstN)
    $changed(board) |-> $past(commitGen || clearBoard))
    else $error("boardBuffer: board moved without commit or clear");

endmodule

// ==== verilog/cellRule.sv ====
//----------------------------------------------------------
// rule decision latch and generation activity tracking
// nextCell valid one cycle after readCell
// stallFlag updates only on commitGen or clearBoard
//----------------------------------------------------------
`timescale 1ns/10ps
`include "lifeGrid_params.svh"

module cellRule
  import lifeRulePkg::*;
(
  input  logic          clka,
  input  logic          arstN,
  input  logic          clearBoard,
  input  logic          readCell,
  input  logic          writeCell,
  input  logic          commitGen,
  input  neighborCountT neighborCount,
  output logic          nextCell,
  output logic          stallFlag
);

  // latched "this cell was busy" bit, taken with the decision
  logic cellActive;
  // any written cell busy in this generation
  logic genActive;

  //----------------------------------------------------------
  // decision and activity registers
  //----------------------------------------------------------
  always_ff @(posedge clka or negedge arstN) begin
    if (!arstN) begin
      nextCell   <= 1'b0;
      cellActive <= 1'b0;
      genActive  <= 1'b0;
      stallFlag  <= 1'b0;
    end else if (clearBoard) begin
      nextCell   <= 1'b0;
      cellActive <= 1'b0;
      genActive  <= 1'b0;
      stallFlag  <= 1'b0;
    end else if (readCell) begin
      // alive when count inside the birth window, inclusive
      nextCell   <= (neighborCount >= neighborCountT'(`BIRTH_MIN)) &&
                    (neighborCount <= neighborCountT'(`BIRTH_MAX));
      cellActive <= (neighborCount >= neighborCountT'(`ACTIVE_MIN));
    end else if (writeCell) begin
      // activity only counts once the decision is written back
      genActive  <= genActive | cellActive;
    end else if (commitGen) begin
      // quiet generation when nothing written was busy
      stallFlag  <= ~genActive;
      genActive  <= 1'b0;
    end
  end

  //----------------------------------------------------------
  // checks
  //----------------------------------------------------------
  // sequencer must issue at most one strobe per edge
  aOneStrobe: assert property (@(posedge clka) disable iff (!arstN)
    $onehot0({clearBoard, readCell, writeCell, commitGen}))
    else $error("cellRule: more than one strobe high");

  // counter output stays within the neighbourhood size
  aCountRange: assert property (@(posedge clka) disable iff (!arstN)
    neighborCount <= neighborCountT'(MAX_NEIGHBORS))
    else $error("cellRule: neighbour count above %0d", MAX_NEIGHBORS);

endmodule

// ==== verilog/neighborCounter.sv ====
//----------------------------------------------------------
// combinational torus neighbour sum for the indexed cell
// zero latency, reads the visible board only
// wrap uses modulo on the grid macros
//----------------------------------------------------------
`timescale 1ns/10ps
`include "lifeGrid_params.svh"

module neighborCounter
  import lifeBoardPkg::*, lifeRulePkg::*;
(
  input  boardT         board,
  input  cellIndexT     cellIndex,
  output neighborCountT neighborCount
);

  //----------------------------------------------------------
  // centre cell position
  //----------------------------------------------------------
  // row and column of the cell under evaluation
  int centreRow;
  int centreCol;

  // split the row-major index
  assign centreRow = int'(cellIndex) / `GRID_COLS;
  assign centreCol = int'(cellIndex) % `GRID_COLS;

  //----------------------------------------------------------
  // neighbour sum
  //----------------------------------------------------------
  // walk the 3x3 window around the centre
  always_comb begin : torusSum
    neighborCountT sum;
    int nbrRow;
    int nbrCol;
    sum = '0;
    nbrRow = 0;
    nbrCol = 0;
    for (int dr = -1; dr <= 1; dr++) begin
      for (int dc = -1; dc <= 1; dc++) begin
        // add one grid span first so the modulo never sees a negative
        nbrRow = (centreRow + dr + `GRID_ROWS) % `GRID_ROWS;
        nbrCol = (centreCol + dc + `GRID_COLS) % `GRID_COLS;
        // centre itself is not a neighbour
        if (!(dr == 0 && dc == 0)) begin
          sum = sum + neighborCountT'(board[nbrRow * `GRID_COLS + nbrCol]);
        end
      end
    end
    // 0 to 8 live cells
    neighborCount = sum;
  end

endmodule

// ==== verilog/lifeRulePkg.sv ====
//----------------------------------------------------------
// rule-side types
// count covers 0 to 8 neighbours of a Moore neighbourhood
//----------------------------------------------------------
`include "lifeGrid_params.svh"

package lifeRulePkg;

  //----------------------------------------------------------
  // neighbourhood size
  //----------------------------------------------------------
  // eight surrounding cells on the torus
  localparam int MAX_NEIGHBORS = 8;

  //----------------------------------------------------------
  // neighbour count
  //----------------------------------------------------------
  // must hold MAX_NEIGHBORS itself, so 4 bits
  typedef logic [$clog2(MAX_NEIGHBORS+1)-1:0] neighborCountT;

endpackage

// ==== verilog/lifeBoardPkg.sv ====
//----------------------------------------------------------
// board and cell-index types
// board is row-major, cell index = row * GRID_COLS + column
//----------------------------------------------------------
`include "lifeGrid_params.svh"

package lifeBoardPkg;

  //----------------------------------------------------------
  // board storage
  //----------------------------------------------------------
  // one bit per cell, bit 0 is row 0 column 0
  typedef logic [`CELL_COUNT-1:0] boardT;

  //----------------------------------------------------------
  // cell addressing
  //----------------------------------------------------------
  // wide enough for every cell of the grid
  typedef logic [$clog2(`CELL_COUNT)-1:0] cellIndexT;

endpackage

// ==== verilog/lifeGrid_params.svh ====
//----------------------------------------------------------
// grid geometry and rule bounds for the 4x4 life board
// geometry macros assume a power-of-two grid for cheap wrap
// rule bounds are inclusive neighbour counts
//----------------------------------------------------------
`ifndef LIFE_GRID_PARAMS_SVH
`define LIFE_GRID_PARAMS_SVH

// board geometry
`define GRID_ROWS 4
`define GRID_COLS 4

// one bit per cell, row-major
`define CELL_COUNT (`GRID_ROWS * `GRID_COLS)

//----------------------------------------------------------
// rule bounds
//----------------------------------------------------------
// lowest live-neighbour count that gives a live cell
`define BIRTH_MIN 3
// highest live-neighbour count that gives a live cell
`define BIRTH_MAX 5
// written cell at or above this count marks the generation active
`define ACTIVE_MIN 2

`endif
